// ==== common/mmio_bus_if.sv ====
`timescale 1ns/1ps

interface mmio_bus_if
    import mmio_types_pkg::*, mmio_map_pkg::*;
();

    wr_target_e wr_target;  // WR_NONE when no store
    word_t      wdata;
    fb_addr_t   fb_addr;    // pixel index from the store address
    rd_source_e rd_source;  // RD_NONE when no load or unmapped
    logic       fifo_pop;

    modport ctrl (output wr_target, wdata, fb_addr, rd_source, fifo_pop);
    modport periph (input wr_target, wdata, fb_addr, rd_source, fifo_pop);

endinterface

// ==== common/mmio_map_pkg.sv ====
package mmio_map_pkg;

    import mmio_types_pkg::*;

    // ------------------------------------------------------------------------
    // register addresses
    // ------------------------------------------------------------------------
    localparam word_t ADDR_CYCLE_COUNT   = 32'h8000_0010;
    localparam word_t ADDR_INSTR_COUNT   = 32'h8000_0014;
    localparam word_t ADDR_COUNTER_RESET = 32'h8000_0018;
    localparam word_t ADDR_FIFO_EMPTY    = 32'h8000_0020;
    localparam word_t ADDR_FIFO_DATA     = 32'h8000_0024;
    localparam word_t ADDR_SWITCHES      = 32'h8000_0028;
    localparam word_t ADDR_LEDS          = 32'h8000_0030;
    localparam word_t ADDR_TONE_ENABLE   = 32'h8000_0034;
    localparam word_t ADDR_TONE_PERIOD   = 32'h8000_0038;
    localparam word_t ADDR_AUDIO_FULL    = 32'h8000_0040;
    localparam word_t ADDR_AUDIO_SAMPLE  = 32'h8000_0044;
    localparam word_t ADDR_HDMI_X0       = 32'h8001_0000;
    localparam word_t ADDR_HDMI_X1       = 32'h8001_0004;
    localparam word_t ADDR_HDMI_Y0       = 32'h8001_0008;
    localparam word_t ADDR_HDMI_Y1       = 32'h8001_000c;
    localparam word_t ADDR_HDMI_COLOR    = 32'h8001_0010;
    localparam word_t ADDR_HDMI_FIRE     = 32'h8001_0014;

    localparam logic [7:0] FB_REGION_TAG = 8'h90;  // top address byte of pixel writes

    // store destinations
    typedef enum logic [3:0] {
        WR_NONE, WR_COUNTER_RESET, WR_LEDS, WR_TONE_ENABLE, WR_TONE_PERIOD,
        WR_AUDIO_SAMPLE, WR_FB_PIXEL, WR_HDMI_X0, WR_HDMI_X1, WR_HDMI_Y0,
        WR_HDMI_Y1, WR_HDMI_COLOR, WR_HDMI_FIRE
    } wr_target_e;

    // load sources
    typedef enum logic [2:0] {
        RD_NONE, RD_CYCLE_COUNT, RD_INSTR_COUNT, RD_FIFO_EMPTY,
        RD_FIFO_DATA, RD_SWITCHES, RD_AUDIO_FULL
    } rd_source_e;

endpackage

// ==== common/mmio_types_pkg.sv ====
package mmio_types_pkg;

    // bus and peripheral widths
    localparam int WORD_WIDTH        = 32;
    localparam int LED_WIDTH         = 6;
    localparam int PMOD_WIDTH        = 8;
    localparam int BUTTON_WIDTH      = 4;
    localparam int SWITCH_WIDTH      = 2;
    localparam int TONE_PERIOD_WIDTH = 24;
    localparam int SAMPLE_WIDTH      = 24;
    localparam int COORD_WIDTH       = 10;
    localparam int FB_ADDR_WIDTH     = 20;
    localparam int FIFO_ENTRY_WIDTH  = 8;

    typedef logic [WORD_WIDTH-1:0]        word_t;
    typedef logic [LED_WIDTH-1:0]         led_t;
    typedef logic [PMOD_WIDTH-1:0]        pmod_t;
    typedef logic [BUTTON_WIDTH-1:0]      button_t;
    typedef logic [SWITCH_WIDTH-1:0]      switch_t;
    typedef logic [TONE_PERIOD_WIDTH-1:0] tone_period_t;
    typedef logic [SAMPLE_WIDTH-1:0]      sample_t;
    typedef logic [COORD_WIDTH-1:0]       coord_t;
    typedef logic [FB_ADDR_WIDTH-1:0]     fb_addr_t;
    typedef logic [FIFO_ENTRY_WIDTH-1:0]  fifo_entry_t;

    localparam tone_period_t TONE_PERIOD_RESET = 24'h000555;
    localparam int           BUTTON_FIFO_DEPTH = 32;

endpackage

// ==== gpio/button_fifo.sv ====
`timescale 1ns/1ps

module button_fifo
    import mmio_types_pkg::*;
#(
    parameter int DEPTH = BUTTON_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  fifo_entry_t din,
    input  logic        rd_en,
    output fifo_entry_t dout,
    output logic        full,
    output logic        empty
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    fifo_entry_t          mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 do_wr;
    logic                 do_rd;

    assign full  = (count == (PTR_WIDTH+1)'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;   // overflow dropped
    assign do_rd = rd_en && !empty;
    assign dout  = mem[rd_ptr];      // head visible before the pop

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== gpio/gpio_block.sv ====
`timescale 1ns/1ps

module gpio_block
    import mmio_types_pkg::*, mmio_map_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  button_t     buttons,
    mmio_bus_if.periph  bus,
    output led_t        leds,
    output pmod_t       pmod_leds,
    output logic        fifo_empty,
    output fifo_entry_t fifo_head
);

    logic        fifo_full;
    logic        push_en;
    fifo_entry_t push_data;

    // ------------------------------------------------------------------------
    // LED registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            leds      <= '0;
            pmod_leds <= '0;
        end else if (bus.wr_target == WR_LEDS) begin
            leds      <= bus.wdata[LED_WIDTH-1:0];
            pmod_leds <= bus.wdata[8 +: PMOD_WIDTH];  // second byte
        end
    end

    // push stage, one entry per cycle while held
    always_ff @(posedge clk) begin
        if (rst) begin
            push_en <= 1'b0;
        end else begin
            push_en <= (|buttons) && !fifo_full;
        end
    end

    always_ff @(posedge clk) begin
        push_data <= {{(FIFO_ENTRY_WIDTH-BUTTON_WIDTH){1'b0}}, buttons};
    end

    button_fifo #(
        .DEPTH (BUTTON_FIFO_DEPTH)
    ) u_button_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (push_en),
        .din   (push_data),
        .rd_en (bus.fifo_pop),
        .dout  (fifo_head),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

endmodule

// ==== rtl/audio_regs.sv ====
`timescale 1ns/1ps

module audio_regs
    import mmio_types_pkg::*, mmio_map_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    mmio_bus_if.periph   bus,
    output logic         tone_enable,
    output tone_period_t tone_period,
    output sample_t      audio_din,
    output logic         audio_wr_en
);

    // tone generator control
    always_ff @(posedge clk) begin
        if (rst) begin
            tone_enable <= 1'b0;
            tone_period <= TONE_PERIOD_RESET;
        end else if (bus.wr_target == WR_TONE_ENABLE) begin
            tone_enable <= bus.wdata[0];
        end else if (bus.wr_target == WR_TONE_PERIOD) begin
            tone_period <= bus.wdata[TONE_PERIOD_WIDTH-1:0];
        end
    end

    // sample towards the I2S FIFO, one write per store
    always_ff @(posedge clk) begin
        if (rst) begin
            audio_din   <= '0;
            audio_wr_en <= 1'b0;
        end else begin
            audio_wr_en <= (bus.wr_target == WR_AUDIO_SAMPLE);
            if (bus.wr_target == WR_AUDIO_SAMPLE) begin
                audio_din <= bus.wdata[SAMPLE_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== rtl/mmio_decoder.sv ====
`timescale 1ns/1ps

module mmio_decoder
    import mmio_types_pkg::*, mmio_map_pkg::*;
(
    input  logic  store,
    input  logic  load,
    input  word_t addr,
    input  word_t wdata,
    input  logic  fifo_empty,
    mmio_bus_if.ctrl bus
);

    logic fb_region;

    assign fb_region = (addr[WORD_WIDTH-1 -: 8] == FB_REGION_TAG);

    assign bus.wdata   = wdata;
    assign bus.fb_addr = addr[FB_ADDR_WIDTH-1:0];

    // only a real data load pops, an empty FIFO keeps its pointers
    assign bus.fifo_pop = load && (addr == ADDR_FIFO_DATA) && !fifo_empty;

    // ------------------------------------------------------------------------
    // store decode
    // ------------------------------------------------------------------------
    always_comb begin
        bus.wr_target = WR_NONE;
        if (store) begin
            if (fb_region) begin
                bus.wr_target = WR_FB_PIXEL;
            end else begin
                case (addr)
                    ADDR_COUNTER_RESET: bus.wr_target = WR_COUNTER_RESET;
                    ADDR_LEDS:          bus.wr_target = WR_LEDS;
                    ADDR_TONE_ENABLE:   bus.wr_target = WR_TONE_ENABLE;
                    ADDR_TONE_PERIOD:   bus.wr_target = WR_TONE_PERIOD;
                    ADDR_AUDIO_SAMPLE:  bus.wr_target = WR_AUDIO_SAMPLE;
                    ADDR_HDMI_X0:       bus.wr_target = WR_HDMI_X0;
                    ADDR_HDMI_X1:       bus.wr_target = WR_HDMI_X1;
                    ADDR_HDMI_Y0:       bus.wr_target = WR_HDMI_Y0;
                    ADDR_HDMI_Y1:       bus.wr_target = WR_HDMI_Y1;
                    ADDR_HDMI_COLOR:    bus.wr_target = WR_HDMI_COLOR;
                    ADDR_HDMI_FIRE:     bus.wr_target = WR_HDMI_FIRE;
                    default:            bus.wr_target = WR_NONE;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // load decode
    // ------------------------------------------------------------------------
    always_comb begin
        bus.rd_source = RD_NONE;
        if (load) begin
            case (addr)
                ADDR_CYCLE_COUNT: bus.rd_source = RD_CYCLE_COUNT;
                ADDR_INSTR_COUNT: bus.rd_source = RD_INSTR_COUNT;
                ADDR_FIFO_EMPTY:  bus.rd_source = RD_FIFO_EMPTY;
                ADDR_FIFO_DATA:   bus.rd_source = RD_FIFO_DATA;
                ADDR_SWITCHES:    bus.rd_source = RD_SWITCHES;
                ADDR_AUDIO_FULL:  bus.rd_source = RD_AUDIO_FULL;
                default:          bus.rd_source = RD_NONE;  // unmapped reads as zero
            endcase
        end
    end

endmodule

// ==== rtl/mmio_top.sv ====
`timescale 1ns/1ps

module mmio_top
    import mmio_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         store,
    input  logic         load,
    input  logic         instr_retire,
    input  word_t        addr,
    input  word_t        wdata,
    input  button_t      buttons,
    input  switch_t      switches,
    input  logic         audio_fifo_full,
    input  logic         hdmi_rx_ready,
    output word_t        rd_data,
    output logic         rd_valid,
    output led_t         leds,
    output pmod_t        pmod_leds,
    output logic         tone_enable,
    output tone_period_t tone_period,
    output sample_t      audio_din,
    output logic         audio_wr_en,
    output logic         fb_we,
    output fb_addr_t     fb_addr,
    output logic         fb_data,
    output coord_t       x0,
    output coord_t       x1,
    output coord_t       y0,
    output coord_t       y1,
    output logic         color,
    output logic         hdmi_rx_valid
);

    word_t       cycle_count;
    word_t       instr_count;
    logic        fifo_empty;
    fifo_entry_t fifo_head;

    mmio_bus_if bus ();

    mmio_decoder u_decoder (
        .store      (store),
        .load       (load),
        .addr       (addr),
        .wdata      (wdata),
        .fifo_empty (fifo_empty),
        .bus        (bus.ctrl)
    );

    perf_counters u_counters (
        .clk          (clk),
        .rst          (rst),
        .instr_retire (instr_retire),
        .bus          (bus.periph),
        .cycle_count  (cycle_count),
        .instr_count  (instr_count)
    );

    gpio_block u_gpio (
        .clk        (clk),
        .rst        (rst),
        .buttons    (buttons),
        .bus        (bus.periph),
        .leds       (leds),
        .pmod_leds  (pmod_leds),
        .fifo_empty (fifo_empty),
        .fifo_head  (fifo_head)
    );

    audio_regs u_audio (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus.periph),
        .tone_enable (tone_enable),
        .tone_period (tone_period),
        .audio_din   (audio_din),
        .audio_wr_en (audio_wr_en)
    );

    video_regs u_video (
        .clk           (clk),
        .rst           (rst),
        .hdmi_rx_ready (hdmi_rx_ready),
        .bus           (bus.periph),
        .fb_we         (fb_we),
        .fb_addr       (fb_addr),
        .fb_data       (fb_data),
        .x0            (x0),
        .x1            (x1),
        .y0            (y0),
        .y1            (y1),
        .color         (color),
        .hdmi_rx_valid (hdmi_rx_valid)
    );

    read_mux u_read_mux (
        .clk             (clk),
        .rst             (rst),
        .load            (load),
        .bus             (bus.periph),
        .cycle_count     (cycle_count),
        .instr_count     (instr_count),
        .fifo_empty      (fifo_empty),
        .fifo_head       (fifo_head),
        .switches        (switches),
        .audio_fifo_full (audio_fifo_full),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid)
    );

endmodule

// ==== rtl/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters
    import mmio_types_pkg::*, mmio_map_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  instr_retire,
    mmio_bus_if.periph bus,
    output word_t cycle_count,
    output word_t instr_count
);

    logic clear;

    assign clear = rst || (bus.wr_target == WR_COUNTER_RESET);

    always_ff @(posedge clk) begin
        if (clear) begin
            cycle_count <= '0;
            instr_count <= '0;   // clear beats a retire in the same cycle
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (instr_retire) begin
                instr_count <= instr_count + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/read_mux.sv ====
`timescale 1ns/1ps

module read_mux
    import mmio_types_pkg::*, mmio_map_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    mmio_bus_if.periph  bus,
    input  word_t       cycle_count,
    input  word_t       instr_count,
    input  logic        fifo_empty,
    input  fifo_entry_t fifo_head,
    input  switch_t     switches,
    input  logic        audio_fifo_full,
    output word_t       rd_data,
    output logic        rd_valid
);

    word_t rd_next;

    always_comb begin
        case (bus.rd_source)
            RD_CYCLE_COUNT: rd_next = cycle_count;
            RD_INSTR_COUNT: rd_next = instr_count;
            RD_FIFO_EMPTY:  rd_next = word_t'(fifo_empty);
            RD_FIFO_DATA:   rd_next = word_t'(fifo_head[BUTTON_WIDTH-1:0]);  // button bits only
            RD_SWITCHES:    rd_next = word_t'(switches);
            RD_AUDIO_FULL:  rd_next = word_t'(audio_fifo_full);
            default:        rd_next = '0;
        endcase
    end

    // writeback stage, value as seen in the load cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_data  <= rd_next;
            rd_valid <= load;  // unmapped loads complete too
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the MMIO testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_mmio \
    && ./obj_dir/Vtb_mmio > sim.log 2>&1 \
    && grep -q "^TEST PASS$" sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim.f ====
common/mmio_types_pkg.sv
common/mmio_map_pkg.sv
common/mmio_bus_if.sv
gpio/button_fifo.sv
gpio/gpio_block.sv
video/video_regs.sv
rtl/mmio_decoder.sv
rtl/perf_counters.sv
rtl/audio_regs.sv
rtl/read_mux.sv
rtl/mmio_top.sv
sim/tb_mmio.sv

// ==== sim/tb_mmio.sv ====
`timescale 1ns/1ps

module tb_mmio
    import mmio_types_pkg::*, mmio_map_pkg::*;
();

    logic         clk;
    logic         rst;
    logic         store;
    logic         load;
    logic         instr_retire;
    word_t        addr;
    word_t        wdata;
    button_t      buttons;
    switch_t      switches;
    logic         audio_fifo_full;
    logic         hdmi_rx_ready;
    word_t        rd_data;
    logic         rd_valid;
    led_t         leds;
    pmod_t        pmod_leds;
    logic         tone_enable;
    tone_period_t tone_period;
    sample_t      audio_din;
    logic         audio_wr_en;
    logic         fb_we;
    fb_addr_t     fb_addr;
    logic         fb_data;
    coord_t       x0;
    coord_t       x1;
    coord_t       y0;
    coord_t       y1;
    logic         color;
    logic         hdmi_rx_valid;

    // expected register outputs
    led_t         exp_leds;
    pmod_t        exp_pmod;
    logic         exp_tone_en;
    tone_period_t exp_tone_period;
    sample_t      exp_audio_din;
    logic         exp_audio_wr_en;
    logic         exp_fb_we;
    fb_addr_t     exp_fb_addr;
    logic         exp_fb_data;
    coord_t       exp_x0;
    coord_t       exp_x1;
    coord_t       exp_y0;
    coord_t       exp_y1;
    logic         exp_color;
    logic         exp_hdmi_valid;

    word_t   exp_rd_q[$];   // one entry per outstanding load
    button_t btn_q[$];      // button FIFO contents
    word_t   m_cycle;
    word_t   m_instr;
    integer  seed;
    word_t   rnd;
    int      errors = 0;
    int      checks = 0;
    int      tests_run = 0;
    int      base_errors = 0;

    mmio_top UUT (
        .clk (clk), .rst (rst), .store (store), .load (load),
        .instr_retire (instr_retire), .addr (addr), .wdata (wdata),
        .buttons (buttons), .switches (switches), .audio_fifo_full (audio_fifo_full),
        .hdmi_rx_ready (hdmi_rx_ready), .rd_data (rd_data), .rd_valid (rd_valid),
        .leds (leds), .pmod_leds (pmod_leds), .tone_enable (tone_enable),
        .tone_period (tone_period), .audio_din (audio_din), .audio_wr_en (audio_wr_en),
        .fb_we (fb_we), .fb_addr (fb_addr), .fb_data (fb_data),
        .x0 (x0), .x1 (x1), .y0 (y0), .y1 (y1), .color (color),
        .hdmi_rx_valid (hdmi_rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected load result as held during the load cycle
    function automatic word_t ref_read(word_t a);
        word_t v;
        v = '0;
        case (a)
            ADDR_CYCLE_COUNT: v = m_cycle;
            ADDR_INSTR_COUNT: v = m_instr;
            ADDR_FIFO_EMPTY:  v = {31'd0, btn_q.size() == 0};
            ADDR_FIFO_DATA:   v = (btn_q.size() != 0) ? {28'd0, btn_q[0]} : '0;
            ADDR_SWITCHES:    v = {30'd0, switches};
            ADDR_AUDIO_FULL:  v = {31'd0, audio_fifo_full};
            default:          v = '0;   // unmapped
        endcase
        return v;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // register model of stores landing one edge later
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        exp_audio_wr_en <= 1'b0;
        exp_fb_we       <= 1'b0;
        exp_fb_addr     <= '0;
        exp_fb_data     <= 1'b0;
        exp_hdmi_valid  <= 1'b0;
        if (rst) begin
            exp_leds        <= '0;
            exp_pmod        <= '0;
            exp_tone_en     <= 1'b0;
            exp_tone_period <= 24'h000555;
            exp_audio_din   <= '0;
            {exp_x0, exp_x1, exp_y0, exp_y1, exp_color} <= '0;
        end else if (store) begin
            case (addr)
                ADDR_LEDS: begin
                    exp_leds <= wdata[5:0];
                    exp_pmod <= wdata[15:8];
                end
                ADDR_TONE_ENABLE:  exp_tone_en <= wdata[0];
                ADDR_TONE_PERIOD:  exp_tone_period <= wdata[23:0];
                ADDR_AUDIO_SAMPLE: begin
                    exp_audio_din   <= wdata[23:0];
                    exp_audio_wr_en <= 1'b1;
                end
                ADDR_HDMI_X0:    exp_x0 <= wdata[9:0];
                ADDR_HDMI_X1:    exp_x1 <= wdata[9:0];
                ADDR_HDMI_Y0:    exp_y0 <= wdata[9:0];
                ADDR_HDMI_Y1:    exp_y1 <= wdata[9:0];
                ADDR_HDMI_COLOR: exp_color <= wdata[0];
                ADDR_HDMI_FIRE:  exp_hdmi_valid <= hdmi_rx_ready;
                default: ;
            endcase
            if (addr[31:24] == 8'h90) begin   // pixel region
                exp_fb_we   <= 1'b1;
                exp_fb_addr <= addr[19:0];
                exp_fb_data <= wdata[0];
            end
        end
    end

    // outputs are stable on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_value("leds", word_t'(leds), word_t'(exp_leds));
            check_value("pmod_leds", word_t'(pmod_leds), word_t'(exp_pmod));
            check_value("tone_enable", word_t'(tone_enable), word_t'(exp_tone_en));
            check_value("tone_period", word_t'(tone_period), word_t'(exp_tone_period));
            check_value("audio_din", word_t'(audio_din), word_t'(exp_audio_din));
            check_value("audio_wr_en", word_t'(audio_wr_en), word_t'(exp_audio_wr_en));
            check_value("fb_we", word_t'(fb_we), word_t'(exp_fb_we));
            check_value("fb_addr", word_t'(fb_addr), word_t'(exp_fb_addr));
            check_value("fb_data", word_t'(fb_data), word_t'(exp_fb_data));
            check_value("x0", word_t'(x0), word_t'(exp_x0));
            check_value("x1", word_t'(x1), word_t'(exp_x1));
            check_value("y0", word_t'(y0), word_t'(exp_y0));
            check_value("y1", word_t'(y1), word_t'(exp_y1));
            check_value("color", word_t'(color), word_t'(exp_color));
            check_value("hdmi_rx_valid", word_t'(hdmi_rx_valid), word_t'(exp_hdmi_valid));
            if (rd_valid) begin
                assert (exp_rd_q.size() != 0) else begin
                    $display("rd_valid went high without a pending load");
                    errors++;
                end
                if (exp_rd_q.size() != 0) begin
                    check_value("rd_data", rd_data, exp_rd_q.pop_front());
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------------------
    task automatic drive_idle();
        @(negedge clk);
        store        = 1'b0;
        load         = 1'b0;
        instr_retire = 1'b0;
    endtask

    task automatic store_word(input word_t a, input word_t d);
        @(negedge clk);
        store        = 1'b1;
        load         = 1'b0;
        instr_retire = 1'b0;
        addr         = a;
        wdata        = d;
    endtask

    task automatic load_word(input word_t a);
        @(negedge clk);
        store        = 1'b0;
        load         = 1'b1;
        instr_retire = 1'b0;
        addr         = a;
        wdata        = '0;
        exp_rd_q.push_back(ref_read(a));
        if (a == ADDR_FIFO_DATA && btn_q.size() != 0) begin
            void'(btn_q.pop_front());   // popped at the next edge
        end
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (exp_rd_q.size() != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (exp_rd_q.size() == 0) else begin
            $display("timeout: %0d loads never got rd_valid", exp_rd_q.size());
            errors++;
            exp_rd_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        drive_idle();
        wait_reads_done();
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - base_errors);
        base_errors = errors;
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        int     i;
        int     j;
        int     k;
        int     pulses;
        word_t  a;
        button_t pat;
        seed = 32'hfdd;
        rst = 1'b1;
        store = 1'b0;
        load = 1'b0;
        instr_retire = 1'b0;
        addr = '0;
        wdata = '0;
        buttons = '0;
        switches = '0;
        audio_fifo_full = 1'b0;
        hdmi_rx_ready = 1'b0;
        m_cycle = '0;
        m_instr = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // reset values then LED and tone registers
        check_value("tone_period", word_t'(tone_period), 32'h0000_0555);
        check_value("leds", word_t'(leds), 32'h0);
        for (i = 0; i < 12; i++) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0:    a = ADDR_LEDS;
                2'd1:    a = ADDR_TONE_ENABLE;
                2'd2:    a = ADDR_TONE_PERIOD;
                default: a = 32'h8000_0050;   // nothing there
            endcase
            rnd = $random(seed);
            store_word(a, rnd);
        end
        finish_test("register writes");

        // back to back audio sample and pixel pulses
        for (i = 0; i < 3; i++) begin
            rnd = $random(seed);
            store_word(ADDR_AUDIO_SAMPLE, rnd);
        end
        drive_idle();
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            a = {8'h90, rnd[23:0]};
            rnd = $random(seed);
            store_word(a, rnd);
        end
        finish_test("audio and framebuffer");

        // line registers and a fire gated by ready
        store_word(ADDR_HDMI_X0, $random(seed));
        store_word(ADDR_HDMI_X1, $random(seed));
        store_word(ADDR_HDMI_Y0, $random(seed));
        store_word(ADDR_HDMI_Y1, $random(seed));
        store_word(ADDR_HDMI_COLOR, 32'h1);
        hdmi_rx_ready = 1'b1;
        store_word(ADDR_HDMI_FIRE, 32'h0);
        drive_idle();
        hdmi_rx_ready = 1'b0;
        store_word(ADDR_HDMI_FIRE, 32'h0);
        finish_test("hdmi line");

        // counters after a reset store with a retire in the same cycle
        for (i = 0; i < 2; i++) begin
            rnd = $random(seed);
            k = 5 + int'(rnd[2:0]);
            @(negedge clk);
            store = 1'b1;
            load = 1'b0;
            addr = ADDR_COUNTER_RESET;
            wdata = rnd;
            instr_retire = 1'b1;
            pulses = 0;
            for (j = 1; j < k; j++) begin
                @(negedge clk);
                store = 1'b0;
                rnd = $random(seed);
                instr_retire = rnd[0];
                if (rnd[0]) begin
                    pulses++;
                end
            end
            m_cycle = word_t'(k - 1);
            m_instr = word_t'(pulses);
            load_word(ADDR_CYCLE_COUNT);
            load_word(ADDR_INSTR_COUNT);
        end
        finish_test("counters");

        // button FIFO, switches, audio full and an unmapped load
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            rnd = $random(seed);
            pat = rnd[3:0];
            if (pat == 4'h0) begin
                pat = 4'h1;
            end
            buttons = pat;
            btn_q.push_back(pat);
        end
        @(negedge clk);
        buttons = '0;
        drive_idle();   // last push lands here
        load_word(ADDR_FIFO_EMPTY);
        for (i = 0; i < 6; i++) begin
            load_word(ADDR_FIFO_DATA);
        end
        load_word(ADDR_FIFO_EMPTY);
        for (i = 0; i < 4; i++) begin
            drive_idle();
            switches = switch_t'(i);
            audio_fifo_full = i[0];
            load_word(ADDR_SWITCHES);
            load_word(ADDR_AUDIO_FULL);
        end
        load_word(32'h8000_0050);
        finish_test("reads");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== video/video_regs.sv ====
`timescale 1ns/1ps

module video_regs
    import mmio_types_pkg::*, mmio_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       hdmi_rx_ready,
    mmio_bus_if.periph bus,
    output logic       fb_we,
    output fb_addr_t   fb_addr,
    output logic       fb_data,
    output coord_t     x0,
    output coord_t     x1,
    output coord_t     y0,
    output coord_t     y1,
    output logic       color,
    output logic       hdmi_rx_valid
);

    logic pixel_wr;

    assign pixel_wr = (bus.wr_target == WR_FB_PIXEL);

    // ------------------------------------------------------------------------
    // framebuffer write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            fb_we   <= 1'b0;
            fb_addr <= '0;
            fb_data <= 1'b0;
        end else begin
            fb_we   <= pixel_wr;
            fb_addr <= pixel_wr ? bus.fb_addr : '0;   // idle port shows zero
            fb_data <= pixel_wr ? bus.wdata[0] : 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // line drawer registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            x0    <= '0;
            x1    <= '0;
            y0    <= '0;
            y1    <= '0;
            color <= 1'b0;
        end else begin
            case (bus.wr_target)
                WR_HDMI_X0:    x0 <= bus.wdata[COORD_WIDTH-1:0];
                WR_HDMI_X1:    x1 <= bus.wdata[COORD_WIDTH-1:0];
                WR_HDMI_Y0:    y0 <= bus.wdata[COORD_WIDTH-1:0];
                WR_HDMI_Y1:    y1 <= bus.wdata[COORD_WIDTH-1:0];
                WR_HDMI_COLOR: color <= bus.wdata[0];
                default:       color <= color;
            endcase
        end
    end

    // fire is lost when the line engine is busy
    always_ff @(posedge clk) begin
        if (rst) begin
            hdmi_rx_valid <= 1'b0;
        end else begin
            hdmi_rx_valid <= (bus.wr_target == WR_HDMI_FIRE) && hdmi_rx_ready;
        end
    end

endmodule
